/* files.f */
+incdir+.
dbgPkg.sv
iacUnit.sv
dacUnit.sv
dbsrUnit.sv
dbgEvents.sv
tbDbgEvents.sv

/* Makefile */
# Verilator build for the debug event logic

VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := tbDbgEvents
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Result is taken from the pass line in the log
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tbDbgEvents.sv */
// Testbench for dbgEvents with LFSR stimulus, DBSR reference model and per-cycle checks
`timescale 1ns/100ps
`default_nettype none

`include "dbgEvent_defines.svh"

module tbDbgEvents import dbgPkg::*;
();

    logic                   clk = 1'b0;
    logic                   rstN;
    logic                   instrValid;
    logic                   enIac1;
    logic                   enIac2;
    logic                   memValid;
    logic                   memWrite;
    logic                   enDac1Rd;
    logic                   enDac1Wr;
    logic                   enDac2Rd;
    logic                   enDac2Wr;
    logic                   msrDE;
    logic                   intDbMode;
    logic                   extDbMode;
    logic [`DBG_ADDR_W-1:0] instrAddr;
    logic [`DBG_ADDR_W-1:0] iac1Addr;
    logic [`DBG_ADDR_W-1:0] iac2Addr;
    logic [`DBG_ADDR_W-1:0] memAddr;
    logic [`DBG_ADDR_W-1:0] dac1Addr;
    logic [`DBG_ADDR_W-1:0] dac2Addr;
    cmpModeT                iacMode;
    cmpModeT                dacMode;
    dacSizeT                dac1Size;
    dacSizeT                dac2Size;
    sprOpT                  sprOp;
    dbsrT                   sprData;
    dbsrT                   dbsr;
    logic                   summary;
    logic                   dbgIntrp;
    logic                   stopReq;

    // Model state and bookkeeping
    dbsrT        modelDbsr;
    logic [5:0]  evPend;
    logic [31:0] lfsrState;
    int          errCount = 0;
    int          timeoutCount = 0;

    always #4 clk = ~clk;

    dbgEvents i_dut
    (
        .clk_i        (clk),
        .rstN_i       (rstN),
        .instrValid_i (instrValid),
        .instrAddr_i  (instrAddr),
        .iac1Addr_i   (iac1Addr),
        .iac2Addr_i   (iac2Addr),
        .iacMode_i    (iacMode),
        .enIac1_i     (enIac1),
        .enIac2_i     (enIac2),
        .memValid_i   (memValid),
        .memWrite_i   (memWrite),
        .memAddr_i    (memAddr),
        .dac1Addr_i   (dac1Addr),
        .dac2Addr_i   (dac2Addr),
        .dacMode_i    (dacMode),
        .dac1Size_i   (dac1Size),
        .dac2Size_i   (dac2Size),
        .enDac1Rd_i   (enDac1Rd),
        .enDac1Wr_i   (enDac1Wr),
        .enDac2Rd_i   (enDac2Rd),
        .enDac2Wr_i   (enDac2Wr),
        .sprOp_i      (sprOp),
        .sprData_i    (sprData),
        .msrDE_i      (msrDE),
        .intDbMode_i  (intDbMode),
        .extDbMode_i  (extDbMode),
        .dbsr_o       (dbsr),
        .summary_o    (summary),
        .dbgIntrp_o   (dbgIntrp),
        .stopReq_o    (stopReq)
    );

    // ****************************************
    // Random source and reference model
    // ****************************************

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hB4BCD35C) : (lfsrState >> 1);
            val = {val[30:0], lfsrState[0]};
        end
        return val;
    endfunction

    // Low address bits left out of a DAC exact match
    function automatic int ignoredBits(input dacSizeT size);
        case (size)
            SIZE_HALF: return 1;
            SIZE_WORD: return 2;
            SIZE_LINE: return 5;
            default:   return 0;
        endcase
    endfunction

    function automatic logic [1:0] iacHits();
        logic inRng;
        logic [1:0] hit;
        inRng = (instrAddr >= iac1Addr) && (instrAddr < iac2Addr);
        if (iacMode == CMP_RANGE)
            hit = {inRng, inRng};
        else if (iacMode == CMP_XRANGE)
            hit = {!inRng, !inRng};
        else
            hit = {(instrAddr >> 2) == (iac2Addr >> 2), (instrAddr >> 2) == (iac1Addr >> 2)};
        return hit & {enIac2, enIac1} & {2{instrValid}};
    endfunction

    function automatic logic [3:0] dacHits();
        logic [31:0] m1;
        logic [31:0] m2;
        logic        inRng;
        logic        h1;
        logic        h2;
        m1 = 32'hFFFFFFFF << ignoredBits(dac1Size);
        m2 = 32'hFFFFFFFF << ignoredBits(dac2Size);
        inRng = (memAddr >= dac1Addr) && (memAddr < dac2Addr);
        h1 = (dacMode == CMP_EXACT) ? ((memAddr & m1) == (dac1Addr & m1)) :
             (dacMode == CMP_RANGE) ? inRng : !inRng;
        h2 = (dacMode == CMP_EXACT) ? ((memAddr & m2) == (dac2Addr & m2)) :
             (dacMode == CMP_RANGE) ? inRng : !inRng;
        // Returned in DBSR order DAC1R to DAC2W from bit 0 up
        return {h2 & memWrite & enDac2Wr, h2 & !memWrite & enDac2Rd,
                h1 & memWrite & enDac1Wr, h1 & !memWrite & enDac1Rd} & {4{memValid}};
    endfunction

    // Mirrors the event flag and DBSR stages with inputs sampled before this edge's drives
    always @(posedge clk)
    begin
        dbsrT hwVec;
        dbsrT setTerm;
        dbsrT clrTerm;
        if (!rstN)
        begin
            modelDbsr = '0;
            evPend = '0;
        end
        else
        begin
            hwVec = {(|evPend) & !msrDE, evPend};
            setTerm = (sprOp == SPR_SET) ? sprData : '0;
            clrTerm = (sprOp == SPR_CLEAR) ? sprData : '0;
            // Hardware set beats a same-cycle clear
            modelDbsr = setTerm | (modelDbsr & ~clrTerm) | hwVec;
            evPend = {dacHits(), iacHits()};
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk)
    begin
        logic expSummary;
        expSummary = |modelDbsr[`DBSR_DAC2W:`DBSR_IAC1];
        if (dbsr !== modelDbsr)
        begin
            $display("CHECK FAILED at %0t: dbsr_o is %b, expected %b", $time, dbsr, modelDbsr);
            errCount++;
        end
        if (summary !== expSummary)
        begin
            $display("CHECK FAILED at %0t: summary_o is %b", $time, summary);
            errCount++;
        end
        if (dbgIntrp !== (intDbMode & msrDE & expSummary))
        begin
            $display("CHECK FAILED at %0t: dbgIntrp_o is %b", $time, dbgIntrp);
            errCount++;
        end
        if (stopReq !== (extDbMode & expSummary))
        begin
            $display("CHECK FAILED at %0t: stopReq_o is %b", $time, stopReq);
            errCount++;
        end
    end

    // ****************************************
    // Stimulus tasks
    // ****************************************

    // Compare registers and addresses sit within 64 bytes of base
    task automatic driveRandom(input logic [31:0] base);
        logic [1:0] modeBits;
        logic [3:0] opSel;
        instrValid <= 1'(takeBits(1));
        instrAddr  <= base + takeBits(6);
        iac1Addr   <= base + takeBits(6);
        iac2Addr   <= base + takeBits(6);
        memValid   <= 1'(takeBits(1));
        memWrite   <= 1'(takeBits(1));
        memAddr    <= base + takeBits(6);
        dac1Addr   <= base + takeBits(6);
        dac2Addr   <= base + takeBits(6);
        modeBits = 2'(takeBits(2));
        if (modeBits == 2'b11)
            modeBits = 2'b00;
        iacMode <= cmpModeT'(modeBits);
        modeBits = 2'(takeBits(2));
        if (modeBits == 2'b11)
            modeBits = 2'b01;
        dacMode   <= cmpModeT'(modeBits);
        dac1Size  <= dacSizeT'(2'(takeBits(2)));
        dac2Size  <= dacSizeT'(2'(takeBits(2)));
        enIac1    <= 1'(takeBits(1));
        enIac2    <= 1'(takeBits(1));
        enDac1Rd  <= 1'(takeBits(1));
        enDac1Wr  <= 1'(takeBits(1));
        enDac2Rd  <= 1'(takeBits(1));
        enDac2Wr  <= 1'(takeBits(1));
        msrDE     <= 1'(takeBits(1));
        intDbMode <= 1'(takeBits(1));
        extDbMode <= 1'(takeBits(1));
        // SPR access one cycle in four with sets and clears equally likely
        opSel = 4'(takeBits(4));
        sprOp   <= (opSel >= 4'd14) ? SPR_CLEAR : ((opSel >= 4'd12) ? SPR_SET : SPR_NONE);
        sprData <= dbsrT'(takeBits(`DBSR_W));
    endtask

    task automatic driveIdle();
        instrValid <= 1'b0;
        memValid   <= 1'b0;
        sprOp      <= SPR_NONE;
    endtask

    task automatic waitForBit(input int bitPos, input int maxCycles);
        int count;
        count = 0;
        do
        begin
            @(negedge clk);
            count++;
        end
        while (!dbsr[bitPos] && count < maxCycles);
        if (!dbsr[bitPos])
        begin
            $display("Timed out waiting for DBSR bit %0d to set", bitPos);
            timeoutCount++;
        end
    endtask

    // ****************************************
    // Test sequence
    // ****************************************

    initial
    begin
        logic [31:0] base;
        lfsrState = 32'ha16e;
        rstN = 1'b0;
        {instrValid, enIac1, enIac2, memValid, memWrite} = '0;
        {enDac1Rd, enDac1Wr, enDac2Rd, enDac2Wr} = '0;
        {msrDE, intDbMode, extDbMode} = '0;
        {instrAddr, iac1Addr, iac2Addr, memAddr, dac1Addr, dac2Addr} = '0;
        iacMode  = CMP_EXACT;
        dacMode  = CMP_EXACT;
        dac1Size = SIZE_BYTE;
        dac2Size = SIZE_BYTE;
        sprOp    = SPR_NONE;
        sprData  = '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        // Strobes with every enable off leave the DBSR clear
        base = takeBits(32);
        for (int cycle = 0; cycle < 40; cycle++)
        begin
            @(posedge clk);
            driveRandom(base);
            {enIac1, enIac2, enDac1Rd, enDac1Wr, enDac2Rd, enDac2Wr} <= '0;
            sprOp <= SPR_NONE;
        end

        // IAC1 word match with different low address bits
        @(posedge clk);
        iacMode    <= CMP_EXACT;
        iac1Addr   <= base;
        instrAddr  <= base | 32'h3;
        enIac1     <= 1'b1;
        instrValid <= 1'b1;
        memValid   <= 1'b0;
        msrDE      <= 1'b1;
        @(posedge clk);
        driveIdle();
        waitForBit(`DBSR_IAC1, 8);

        // DAC2 store inside one 32-byte line while MSR[DE] is clear
        @(posedge clk);
        dacMode  <= CMP_EXACT;
        dac2Size <= SIZE_LINE;
        dac2Addr <= base & ~32'h1f;
        memAddr  <= base | 32'h1f;
        memWrite <= 1'b1;
        enDac2Wr <= 1'b1;
        memValid <= 1'b1;
        msrDE    <= 1'b0;
        @(posedge clk);
        driveIdle();
        waitForBit(`DBSR_DAC2W, 8);

        // Clearing every event bit leaves only IMPREC and drops the summary
        @(posedge clk);
        sprOp   <= SPR_CLEAR;
        sprData <= ~(dbsrT'(1) << `DBSR_IMPREC);
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        if (dbsr !== (dbsrT'(1) << `DBSR_IMPREC) || summary !== 1'b0)
        begin
            $display("CHECK FAILED at %0t: dbsr_o is %b and summary_o %b with only IMPREC left",
                     $time, dbsr, summary);
            errCount++;
        end

        @(posedge clk);
        sprOp   <= SPR_CLEAR;
        sprData <= '1;
        @(posedge clk);
        driveIdle();

        // Random traffic with a new address window every 64 cycles
        for (int cycle = 0; cycle < 4000; cycle++)
        begin
            @(posedge clk);
            if (cycle % 64 == 0)
                base = takeBits(32);
            driveRandom(base);
        end
        @(posedge clk);
        driveIdle();
        repeat (3) @(posedge clk);

        $display("Mismatches: %0d, timeouts: %0d", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dbgEvents.sv */
// Debug event top level joining the IAC, DAC and DBSR units
`timescale 1ns/100ps
`default_nettype none

`include "dbgEvent_defines.svh"

module dbgEvents import dbgPkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rstN_i,
    // Decode-stage instruction
    input  wire logic                   instrValid_i,
    input  wire logic [`DBG_ADDR_W-1:0] instrAddr_i,
    input  wire logic [`DBG_ADDR_W-1:0] iac1Addr_i,
    input  wire logic [`DBG_ADDR_W-1:0] iac2Addr_i,
    input  wire cmpModeT                iacMode_i,
    input  wire logic                   enIac1_i,
    input  wire logic                   enIac2_i,
    // Execute-stage load or store
    input  wire logic                   memValid_i,
    input  wire logic                   memWrite_i,
    input  wire logic [`DBG_ADDR_W-1:0] memAddr_i,
    input  wire logic [`DBG_ADDR_W-1:0] dac1Addr_i,
    input  wire logic [`DBG_ADDR_W-1:0] dac2Addr_i,
    input  wire cmpModeT                dacMode_i,
    input  wire dacSizeT                dac1Size_i,
    input  wire dacSizeT                dac2Size_i,
    input  wire logic                   enDac1Rd_i,
    input  wire logic                   enDac1Wr_i,
    input  wire logic                   enDac2Rd_i,
    input  wire logic                   enDac2Wr_i,
    // DBSR software access and modes
    input  wire sprOpT                  sprOp_i,
    input  wire dbsrT                   sprData_i,
    input  wire logic                   msrDE_i,
    input  wire logic                   intDbMode_i,
    input  wire logic                   extDbMode_i,
    output dbsrT                        dbsr_o,
    output logic                        summary_o,
    output logic                        dbgIntrp_o,
    output logic                        stopReq_o
);

    // Registered event pulses into the DBSR
    logic [1:0] iacEvent;
    logic [3:0] dacEvent;

    iacUnit i_iacUnit
    (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .instrValid_i (instrValid_i),
        .instrAddr_i  (instrAddr_i),
        .iac1Addr_i   (iac1Addr_i),
        .iac2Addr_i   (iac2Addr_i),
        .iacMode_i    (iacMode_i),
        .enIac1_i     (enIac1_i),
        .enIac2_i     (enIac2_i),
        .iacEvent_o   (iacEvent)
    );

    dacUnit i_dacUnit
    (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .memValid_i (memValid_i),
        .memWrite_i (memWrite_i),
        .memAddr_i  (memAddr_i),
        .dac1Addr_i (dac1Addr_i),
        .dac2Addr_i (dac2Addr_i),
        .dacMode_i  (dacMode_i),
        .dac1Size_i (dac1Size_i),
        .dac2Size_i (dac2Size_i),
        .enDac1Rd_i (enDac1Rd_i),
        .enDac1Wr_i (enDac1Wr_i),
        .enDac2Rd_i (enDac2Rd_i),
        .enDac2Wr_i (enDac2Wr_i),
        .dacEvent_o (dacEvent)
    );

    dbsrUnit i_dbsrUnit
    (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .iacEvent_i  (iacEvent),
        .dacEvent_i  (dacEvent),
        .sprOp_i     (sprOp_i),
        .sprData_i   (sprData_i),
        .msrDE_i     (msrDE_i),
        .intDbMode_i (intDbMode_i),
        .extDbMode_i (extDbMode_i),
        .dbsr_o      (dbsr_o),
        .summary_o   (summary_o),
        .dbgIntrp_o  (dbgIntrp_o),
        .stopReq_o   (stopReq_o)
    );

endmodule

`default_nettype wire

/* dbsrUnit.sv */
// Debug status register with software set and clear, summary, interrupt and stop request
`timescale 1ns/100ps
`default_nettype none

`include "dbgEvent_defines.svh"

module dbsrUnit import dbgPkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rstN_i,
    input  wire logic [1:0] iacEvent_i,
    input  wire logic [3:0] dacEvent_i,
    input  wire sprOpT      sprOp_i,
    input  wire dbsrT       sprData_i,
    input  wire logic       msrDE_i,
    input  wire logic       intDbMode_i,
    input  wire logic       extDbMode_i,
    output dbsrT            dbsr_o,
    output logic            summary_o,
    output logic            dbgIntrp_o,
    output logic            stopReq_o
);

    dbsrT hwSet;
    dbsrT codeSet;
    dbsrT codeClr;
    dbsrT dbsrNxt;
    logic anyHwEvent;

    // ****************************************
    // Hardware set terms
    // ****************************************

    always_comb
    begin
        hwSet                = '0;
        hwSet[`DBSR_IAC1]    = iacEvent_i[0];
        hwSet[`DBSR_IAC2]    = iacEvent_i[1];
        hwSet[`DBSR_DAC1R]   = dacEvent_i[0];
        hwSet[`DBSR_DAC1W]   = dacEvent_i[1];
        hwSet[`DBSR_DAC2R]   = dacEvent_i[2];
        hwSet[`DBSR_DAC2W]   = dacEvent_i[3];
        // Event recorded while debug interrupts are masked
        hwSet[`DBSR_IMPREC]  = anyHwEvent & ~msrDE_i;
    end

    assign anyHwEvent = (|iacEvent_i) | (|dacEvent_i);

    // ****************************************
    // Software set and clear terms
    // ****************************************

    assign codeSet = (sprOp_i == SPR_SET)   ? sprData_i : '0;
    assign codeClr = (sprOp_i == SPR_CLEAR) ? sprData_i : '0;

    // Hardware ORs on last so it wins over a clear in the same cycle
    assign dbsrNxt = codeSet | (dbsr_o & ~codeClr) | hwSet;

    always_ff @(posedge clk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            dbsr_o <= '0;
        end
        else
        begin
            dbsr_o <= dbsrNxt;
        end
    end

    // ****************************************
    // Summary, interrupt and stop request
    // ****************************************

    // IMPREC alone does not raise the summary
    assign summary_o  = |dbsr_o[`DBSR_DAC2W:`DBSR_IAC1];
    assign dbgIntrp_o = intDbMode_i & msrDE_i & summary_o;
    assign stopReq_o  = extDbMode_i & summary_o;

    // A cleared bit with no competing event is gone on the next cycle
    for (genvar bitIdx = 0; bitIdx < `DBSR_W; bitIdx++)
    begin : gClrChk
        assert property (@(posedge clk_i) disable iff (!rstN_i)
            (sprOp_i == SPR_CLEAR && sprData_i[bitIdx] && dbsr_o[bitIdx]
             && !hwSet[bitIdx]) |=> !dbsr_o[bitIdx])
            else $error("DBSR bit %0d survived a software clear", bitIdx);
    end

endmodule

`default_nettype wire

/* dacUnit.sv */
// Data address compare unit with size masking and writeback-stage event flags
`timescale 1ns/100ps
`default_nettype none

`include "dbgEvent_defines.svh"

module dacUnit import dbgPkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rstN_i,
    input  wire logic                   memValid_i,
    input  wire logic                   memWrite_i,
    input  wire logic [`DBG_ADDR_W-1:0] memAddr_i,
    input  wire logic [`DBG_ADDR_W-1:0] dac1Addr_i,
    input  wire logic [`DBG_ADDR_W-1:0] dac2Addr_i,
    input  wire cmpModeT                dacMode_i,
    input  wire dacSizeT                dac1Size_i,
    input  wire dacSizeT                dac2Size_i,
    input  wire logic                   enDac1Rd_i,
    input  wire logic                   enDac1Wr_i,
    input  wire logic                   enDac2Rd_i,
    input  wire logic                   enDac2Wr_i,
    output logic [3:0]                  dacEvent_o
);

    logic [`DBG_ADDR_W-1:0] dac1Mask;
    logic [`DBG_ADDR_W-1:0] dac2Mask;
    logic                   dac1Exact;
    logic                   dac2Exact;
    logic                   inRange;
    logic                   dac1Hit;
    logic                   dac2Hit;
    logic [3:0]             dacEventNxt;

    // Ones where address bits take part in an exact match
    function automatic logic [`DBG_ADDR_W-1:0] sizeMask(input dacSizeT size);
        logic [`DBG_ADDR_W-1:0] mask;
        mask = '1;
        case (size)
            SIZE_HALF: mask[0]   = 1'b0;
            SIZE_WORD: mask[1:0] = 2'b00;
            // 32-byte cache line
            SIZE_LINE: mask[4:0] = 5'b00000;
            default:   mask      = '1;
        endcase
        return mask;
    endfunction

    // ****************************************
    // Execute-stage compare
    // ****************************************

    assign dac1Mask  = sizeMask(dac1Size_i);
    assign dac2Mask  = sizeMask(dac2Size_i);
    assign dac1Exact = ((memAddr_i ^ dac1Addr_i) & dac1Mask) == '0;
    assign dac2Exact = ((memAddr_i ^ dac2Addr_i) & dac2Mask) == '0;

    // Range check ignores the size setting and uses full addresses
    assign inRange = (memAddr_i >= dac1Addr_i) && (memAddr_i < dac2Addr_i);

    always_comb
    begin
        case (dacMode_i)
            CMP_EXACT:
            begin
                dac1Hit = dac1Exact;
                dac2Hit = dac2Exact;
            end
            CMP_RANGE:
            begin
                dac1Hit = inRange;
                dac2Hit = inRange;
            end
            CMP_XRANGE:
            begin
                dac1Hit = ~inRange;
                dac2Hit = ~inRange;
            end
            default:
            begin
                dac1Hit = 1'b0;
                dac2Hit = 1'b0;
            end
        endcase
    end

    // Split by direction, then gate with each bit's own enable
    assign dacEventNxt[0] = memValid_i & dac1Hit & ~memWrite_i & enDac1Rd_i;
    assign dacEventNxt[1] = memValid_i & dac1Hit &  memWrite_i & enDac1Wr_i;
    assign dacEventNxt[2] = memValid_i & dac2Hit & ~memWrite_i & enDac2Rd_i;
    assign dacEventNxt[3] = memValid_i & dac2Hit &  memWrite_i & enDac2Wr_i;

    // ****************************************
    // Writeback-stage event flags
    // ****************************************

    always_ff @(posedge clk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            dacEvent_o <= 4'b0000;
        end
        else
        begin
            dacEvent_o <= dacEventNxt;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstN_i)
        memValid_i |-> !$isunknown(memAddr_i))
        else $error("Unknown data address with memValid_i high");

    // A single access is either a load or a store
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        !(dacEvent_o[0] && dacEvent_o[1]) && !(dacEvent_o[2] && dacEvent_o[3]))
        else $error("DAC read and write flags set together");

endmodule

`default_nettype wire

/* iacUnit.sv */
// Instruction address compare unit with registered execute-stage event flags
`timescale 1ns/100ps
`default_nettype none

`include "dbgEvent_defines.svh"

module iacUnit import dbgPkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rstN_i,
    input  wire logic                   instrValid_i,
    input  wire logic [`DBG_ADDR_W-1:0] instrAddr_i,
    input  wire logic [`DBG_ADDR_W-1:0] iac1Addr_i,
    input  wire logic [`DBG_ADDR_W-1:0] iac2Addr_i,
    input  wire cmpModeT                iacMode_i,
    input  wire logic                   enIac1_i,
    input  wire logic                   enIac2_i,
    output logic [1:0]                  iacEvent_o
);

    // Word address match per comparator
    logic       iac1Exact;
    logic       iac2Exact;
    // Address inside [IAC1, IAC2)
    logic       inRange;
    logic [1:0] cmpHit;
    logic [1:0] iacEventNxt;

    // ****************************************
    // Decode-stage compare
    // ****************************************

    // Instructions are word aligned so bits 1:0 never take part
    assign iac1Exact = instrAddr_i[`DBG_ADDR_W-1:2] == iac1Addr_i[`DBG_ADDR_W-1:2];
    assign iac2Exact = instrAddr_i[`DBG_ADDR_W-1:2] == iac2Addr_i[`DBG_ADDR_W-1:2];

    // IAC1 is the inclusive low bound, IAC2 the exclusive high bound
    assign inRange = (instrAddr_i >= iac1Addr_i) && (instrAddr_i < iac2Addr_i);

    always_comb
    begin
        case (iacMode_i)
            CMP_EXACT:
            begin
                cmpHit = {iac2Exact, iac1Exact};
            end
            // Range modes report on both comparators
            CMP_RANGE:
            begin
                cmpHit = {2{inRange}};
            end
            CMP_XRANGE:
            begin
                cmpHit = {2{~inRange}};
            end
            default:
            begin
                cmpHit = 2'b00;
            end
        endcase
    end

    // Qualify with the strobe and the per-comparator enables
    assign iacEventNxt = cmpHit & {enIac2_i, enIac1_i} & {2{instrValid_i}};

    // ****************************************
    // Execute-stage event flags
    // ****************************************

    always_ff @(posedge clk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            iacEvent_o <= 2'b00;
        end
        else
        begin
            // One-cycle pulse, reloaded every cycle
            iacEvent_o <= iacEventNxt;
        end
    end

    // An execute-stage event always traces back to a decode strobe
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        (|iacEvent_o) |-> $past(instrValid_i))
        else $error("IAC event without a preceding instruction strobe");

endmodule

`default_nettype wire

/* dbgPkg.sv */
// Debug event package with compare mode, DAC size, SPR operation and DBSR types
`default_nettype none

package dbgPkg;

    `include "dbgEvent_defines.svh"

    // Address compare mode, shared by the IAC and DAC pairs
    typedef enum logic [1:0]
    {
        CMP_EXACT  = 2'b00,
        CMP_RANGE  = 2'b01,
        CMP_XRANGE = 2'b10
    } cmpModeT;

    // DAC exact match granularity
    typedef enum logic [1:0]
    {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_LINE = 2'b11
    } dacSizeT;

    // Software access to the DBSR this cycle
    typedef enum logic [1:0]
    {
        SPR_NONE  = 2'b00,
        SPR_SET   = 2'b01,
        SPR_CLEAR = 2'b10
    } sprOpT;

    typedef logic [`DBSR_W-1:0] dbsrT;

endpackage

`default_nettype wire

/* dbgEvent_defines.svh */
// Address width, DBSR width and DBSR bit position macros
`ifndef DBG_EVENT_DEFINES_SVH
`define DBG_EVENT_DEFINES_SVH

// ****************************************
// Widths
// ****************************************

// Instruction and data effective address width
`define DBG_ADDR_W 32
// Implemented DBSR bits
`define DBSR_W 7

// ****************************************
// DBSR bit positions
// ****************************************

`define DBSR_IAC1   0
`define DBSR_IAC2   1
`define DBSR_DAC1R  2
`define DBSR_DAC1W  3
`define DBSR_DAC2R  4
`define DBSR_DAC2W  5
// Event seen while MSR[DE] was clear
`define DBSR_IMPREC 6

`endif
